// ==== source/i2c_pkg.sv ====
// Shared widths, types and slot timing for the I2C master.
// One dri_clk cycle is a quarter of an SCL period.
`default_nettype none

package i2c_pkg;

    // ------------------------------------------------------------
    // widths and payload types
    // ------------------------------------------------------------
    localparam int DEV_ADDR_W  = 7;
    localparam int WORD_ADDR_W = 16;
    localparam int DATA_W      = 8;

    typedef logic [DEV_ADDR_W-1:0]  dev_addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [DATA_W-1:0]      data_t;

    // ------------------------------------------------------------
    // sequencer phases and bus slot kinds
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_DEV_WR,      // device address + write bit
        PH_ADDR_HI,     // upper word address byte
        PH_ADDR_LO,     // lower word address byte
        PH_DATA_WR,
        PH_DEV_RD,      // repeated start + device address + read bit
        PH_DATA_RD,
        PH_STOP
    } phase_e;

    typedef enum logic [2:0] {
        SLOT_IDLE,          // bus released high
        SLOT_START_BYTE,
        SLOT_RESTART_BYTE,
        SLOT_TX_BYTE,
        SLOT_RX_BYTE,       // ends with a nack
        SLOT_STOP
    } slot_e;

    // slot lengths in dri_clk cycles
    localparam int SLOT_LEN_START = 40;     // 4 cycle preamble + 9 bit cells
    localparam int SLOT_LEN_BYTE  = 36;     // 9 bit cells
    localparam int SLOT_LEN_STOP  = 17;

endpackage

`default_nettype wire

// ==== source/i2c_phase_fsm.sv ====
// Transfer sequencer. A request is taken only in idle; exec elsewhere is ignored.
// Word address is 8 or 16 bits per request, one data byte per transfer.
`timescale 1ns/1ps
`default_nettype none

module i2c_phase_fsm #(
    parameter i2c_pkg::dev_addr_t slave_addr = 7'h50
) (
    input  wire                  dri_clk,
    input  wire                  rst_n,
    input  wire                  i2c_exec,
    input  wire                  bit_ctrl,
    input  wire                  i2c_rh_wl,
    input  i2c_pkg::word_addr_t  i2c_addr,
    input  i2c_pkg::data_t       i2c_data_w,
    input  wire                  slot_done,
    output i2c_pkg::slot_e       slot,
    output i2c_pkg::data_t       tx_byte,
    output logic                 i2c_done
);

    import i2c_pkg::*;

    phase_e     phase;
    phase_e     phase_nxt;

    logic       addr16_q;   // 1 for two address bytes
    logic       rd_q;       // 1 for random read
    word_addr_t addr_q;
    data_t      data_q;

    // ------------------------------------------------------------
    // phase register and request latch
    // ------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_IDLE;
            addr16_q <= 1'b0;
            rd_q     <= 1'b0;
            addr_q   <= '0;
            data_q   <= '0;
        end else begin
            phase <= phase_nxt;
            if (phase == PH_IDLE && i2c_exec) begin
                addr16_q <= bit_ctrl;
                rd_q     <= i2c_rh_wl;
                addr_q   <= i2c_addr;
                data_q   <= i2c_data_w;
            end
        end
    end

    // next phase, each busy phase waits for its slot to finish
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: begin
                if (i2c_exec) begin
                    phase_nxt = PH_DEV_WR;
                end
            end
            PH_DEV_WR: begin
                if (slot_done) begin
                    phase_nxt = addr16_q ? PH_ADDR_HI : PH_ADDR_LO;
                end
            end
            PH_ADDR_HI: begin
                if (slot_done) begin
                    phase_nxt = PH_ADDR_LO;
                end
            end
            PH_ADDR_LO: begin
                if (slot_done) begin
                    phase_nxt = rd_q ? PH_DEV_RD : PH_DATA_WR;
                end
            end
            PH_DATA_WR: begin
                if (slot_done) begin
                    phase_nxt = PH_STOP;
                end
            end
            PH_DEV_RD: begin
                if (slot_done) begin
                    phase_nxt = PH_DATA_RD;
                end
            end
            PH_DATA_RD: begin
                if (slot_done) begin
                    phase_nxt = PH_STOP;
                end
            end
            PH_STOP: begin
                if (slot_done) begin
                    phase_nxt = PH_IDLE;
                end
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // slot kind and byte for the bit engine
    // ------------------------------------------------------------
    always_comb begin
        slot    = SLOT_IDLE;
        tx_byte = '0;
        case (phase)
            PH_DEV_WR: begin
                slot    = SLOT_START_BYTE;
                tx_byte = {slave_addr, 1'b0};                   // write bit
            end
            PH_ADDR_HI: begin
                slot    = SLOT_TX_BYTE;
                tx_byte = addr_q[WORD_ADDR_W-1 -: DATA_W];
            end
            PH_ADDR_LO: begin
                slot    = SLOT_TX_BYTE;
                tx_byte = addr_q[DATA_W-1:0];
            end
            PH_DATA_WR: begin
                slot    = SLOT_TX_BYTE;
                tx_byte = data_q;
            end
            PH_DEV_RD: begin
                slot    = SLOT_RESTART_BYTE;
                tx_byte = {slave_addr, 1'b1};                   // read bit
            end
            PH_DATA_RD: slot = SLOT_RX_BYTE;
            PH_STOP:    slot = SLOT_STOP;
            default: ;
        endcase
    end

    // done lands in the first idle cycle after the stop slot
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_done <= 1'b0;
        end else begin
            i2c_done <= (phase == PH_STOP) && slot_done;
        end
    end

endmodule

`default_nettype wire

// ==== source/i2c_bit_engine.sv ====
// Drives SCL and SDA for one slot at a time, four dri_clk cycles per bit.
// Device acks are clocked but never checked. No clock stretching.
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire              dri_clk,
    input  wire              rst_n,
    input  i2c_pkg::slot_e   slot,
    input  i2c_pkg::data_t   tx_byte,
    input  wire              sda_in,
    output logic             slot_done,
    output i2c_pkg::data_t   rx_byte,
    output logic             scl,
    output logic             sda_out,
    output logic             sda_oe
);

    import i2c_pkg::*;

    localparam int CNT_W   = $clog2(SLOT_LEN_START);
    localparam int PRE_LEN = SLOT_LEN_START - SLOT_LEN_BYTE;   // start preamble cycles

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] last_cnt;
    logic [CNT_W-1:0] done_cnt;
    logic [CNT_W-1:0] lc;           // count within the bit cells
    logic [3:0]       bit_idx;      // 0..7 data, 8 ack
    logic [1:0]       quarter;
    logic             start_kind;
    logic             rx_slot;
    logic             in_cells;
    logic             ack_cell;
    data_t            rx_shift;

    // ------------------------------------------------------------
    // slot decode
    // ------------------------------------------------------------
    always_comb begin
        case (slot)
            SLOT_START_BYTE, SLOT_RESTART_BYTE: last_cnt = CNT_W'(SLOT_LEN_START - 1);
            SLOT_TX_BYTE, SLOT_RX_BYTE:         last_cnt = CNT_W'(SLOT_LEN_BYTE - 1);
            SLOT_STOP:                          last_cnt = CNT_W'(SLOT_LEN_STOP - 1);
            default:                            last_cnt = '0;
        endcase
    end

    assign done_cnt   = last_cnt - 1'b1;
    assign start_kind = (slot == SLOT_START_BYTE) || (slot == SLOT_RESTART_BYTE);
    assign rx_slot    = (slot == SLOT_RX_BYTE);
    assign lc         = start_kind ? cnt - CNT_W'(PRE_LEN) : cnt;
    assign in_cells   = !start_kind || (cnt >= CNT_W'(PRE_LEN));
    assign bit_idx    = lc[CNT_W-1:2];
    assign quarter    = lc[1:0];
    assign ack_cell   = (bit_idx == 4'd8);

    // ------------------------------------------------------------
    // slot counter and bus drive
    // ------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            slot_done <= 1'b0;
            scl       <= 1'b1;
            sda_out   <= 1'b1;
            sda_oe    <= 1'b1;
            rx_byte   <= '0;
        end else if (slot == SLOT_IDLE) begin
            cnt       <= '0;
            slot_done <= 1'b0;
            scl       <= 1'b1;      // bus released high
            sda_out   <= 1'b1;
            sda_oe    <= 1'b1;
        end else begin
            cnt       <= (cnt == last_cnt) ? '0 : cnt + 1'b1;
            slot_done <= (cnt == done_cnt);     // seen by sequencer in the last cycle

            if (slot == SLOT_STOP) begin
                case (cnt)
                    CNT_W'(0): begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    CNT_W'(1): scl     <= 1'b1;
                    CNT_W'(3): sda_out <= 1'b1; // sda rises with scl high
                    default: ;
                endcase
            end else if (!in_cells) begin
                // start or repeated start ahead of the first bit
                case (cnt[1:0])
                    2'd0: begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                    end
                    2'd1: begin
                        if (slot == SLOT_START_BYTE) begin
                            sda_out <= 1'b0;    // start while scl idles high
                        end else begin
                            scl <= 1'b1;
                        end
                    end
                    2'd2: begin
                        if (slot == SLOT_RESTART_BYTE) begin
                            sda_out <= 1'b0;    // repeated start
                        end
                    end
                    default: scl <= 1'b0;
                endcase
            end else begin
                case (quarter)
                    2'd0: begin
                        if (ack_cell) begin
                            sda_oe  <= rx_slot; // nack on read, release for device ack
                            sda_out <= 1'b1;
                        end else begin
                            sda_oe  <= !rx_slot;
                            sda_out <= rx_slot ? 1'b1 : tx_byte[~bit_idx[2:0]];   // msb first
                        end
                    end
                    2'd1: scl <= 1'b1;
                    2'd3: begin
                        scl <= 1'b0;
                        if (rx_slot && ack_cell) begin
                            rx_byte <= rx_shift;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // read bits sampled in the middle of scl high
    always_ff @(posedge dri_clk) begin
        if (rx_slot && quarter == 2'd2 && !ack_cell) begin
            rx_shift <= {rx_shift[DATA_W-2:0], sda_in};
        end
    end

endmodule

`default_nettype wire

// ==== source/i2c_master.sv ====
// I2C master for EEPROM-style devices, single-byte write or random read.
// SDA comes out as sda_out/sda_oe/sda_in and the pad resolves the bus.
// SCL is dri_clk divided by four and is always driven.
`timescale 1ns/1ps
`default_nettype none

module i2c_master #(
    parameter i2c_pkg::dev_addr_t slave_addr = 7'h50
) (
    input  wire                  dri_clk,
    input  wire                  rst_n,
    input  wire                  i2c_exec,
    input  wire                  bit_ctrl,      // 1 for 16-bit word address
    input  wire                  i2c_rh_wl,     // 1 for read
    input  i2c_pkg::word_addr_t  i2c_addr,
    input  i2c_pkg::data_t       i2c_data_w,
    input  wire                  sda_in,
    output i2c_pkg::data_t       i2c_data_r,
    output wire                  i2c_done,
    output wire                  scl,
    output wire                  sda_out,
    output wire                  sda_oe
);

    import i2c_pkg::*;

    slot_e slot;
    data_t tx_byte;
    logic  slot_done;

    i2c_phase_fsm #(
        .slave_addr (slave_addr)
    ) u_phase_fsm (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .slot_done  (slot_done),
        .slot       (slot),
        .tx_byte    (tx_byte),
        .i2c_done   (i2c_done)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .slot      (slot),
        .tx_byte   (tx_byte),
        .sda_in    (sda_in),
        .slot_done (slot_done),
        .rx_byte   (i2c_data_r),    // holds until the next read
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

endmodule

`default_nettype wire

// ==== bench/i2c_eeprom_model.sv ====
// Behavioral I2C memory for the testbench. Acks every byte it receives.
// Unwritten locations read 0xFF. Protocol errors raise fault and print a reason.
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_model #(
    parameter i2c_pkg::dev_addr_t dev_addr = 7'h50
) (
    input  wire                  scl,
    input  wire                  sda,
    input  wire                  exp_addr16,    // mode chosen by the testbench
    input  wire                  exp_rd,
    output logic                 sda_pull,
    output logic                 busy,
    output logic                 fault,
    output i2c_pkg::word_addr_t  last_wr_addr,
    output i2c_pkg::data_t       last_wr_data
);

    import i2c_pkg::*;

    data_t      mem [word_addr_t];
    data_t      rx_bytes [$];
    data_t      shift;
    data_t      tx_data;
    word_addr_t word_addr;
    int         bit_cnt;
    int         nbytes;
    logic       restarted;
    logic       sending;
    logic       send_next;

    initial begin
        sda_pull     = 1'b0;
        busy         = 1'b0;
        fault        = 1'b0;
        last_wr_addr = '0;
        last_wr_data = '0;
        sending      = 1'b0;
        send_next    = 1'b0;
    end

    function automatic word_addr_t join_addr();
        if (exp_addr16) begin
            return {rx_bytes[0], rx_bytes[1]};
        end
        return {8'h00, rx_bytes[0]};
    endfunction

    // ------------------------------------------------------------
    // start, repeated start and stop
    // ------------------------------------------------------------
    always @(negedge sda) begin
        if (scl) begin
            if (busy && !exp_rd) begin
                $display("bus model: start seen before the stop of the previous transfer");
                fault = 1'b1;
            end else if (busy) begin
                if (rx_bytes.size() != (exp_addr16 ? 2 : 1)) begin
                    $display("bus model: word address length does not match the mode");
                    fault = 1'b1;
                end else begin
                    word_addr = join_addr();
                end
                restarted = 1'b1;
            end else begin
                restarted = 1'b0;
                rx_bytes.delete();
            end
            busy    = 1'b1;
            bit_cnt = 0;
            nbytes  = 0;
            sending = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl && busy) begin
            if (exp_rd && !restarted) begin
                $display("bus model: read transfer ended without a repeated start");
                fault = 1'b1;
            end else if (!exp_rd) begin
                if (rx_bytes.size() != (exp_addr16 ? 3 : 2)) begin
                    $display("bus model: write byte count does not match the mode");
                    fault = 1'b1;
                end else begin
                    word_addr       = join_addr();
                    mem[word_addr]  = rx_bytes[rx_bytes.size()-1];
                    last_wr_addr    = word_addr;
                    last_wr_data    = rx_bytes[rx_bytes.size()-1];
                end
            end
            busy = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // bit cells
    // ------------------------------------------------------------
    always @(posedge scl) begin
        if (busy) begin
            if (bit_cnt < 8) begin
                if (!sending) begin
                    shift = {shift[6:0], sda};
                end
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8 && !sending) begin
                    if (nbytes == 0) begin
                        if (shift[7:1] != dev_addr) begin
                            $display("bus model: wrong device address 0x%02h", shift[7:1]);
                            fault = 1'b1;
                        end
                        if (shift[0] != restarted) begin
                            $display("bus model: wrong read/write bit after the address");
                            fault = 1'b1;
                        end
                        if (shift[0]) begin
                            send_next = 1'b1;
                            tx_data   = mem.exists(word_addr) ? mem[word_addr] : 8'hFF;
                        end
                    end else begin
                        rx_bytes.push_back(shift);
                    end
                    nbytes = nbytes + 1;
                end
            end else begin
                bit_cnt   = 0;      // ack clock
                sending   = send_next;
                send_next = 1'b0;
            end
        end
    end

    always @(negedge scl) begin
        if (!busy) begin
            sda_pull = 1'b0;
        end else if (bit_cnt == 8) begin
            sda_pull = !sending;    // ack what we received
        end else if (sending) begin
            sda_pull = !tx_data[7-bit_cnt];
        end else begin
            sda_pull = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_i2c_master.sv ====
// Testbench for the I2C master against a behavioral memory device.
// Random requests come from an LFSR with a fixed seed.
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    import i2c_pkg::*;

    localparam int DONE_TIMEOUT = 300;

    logic       dri_clk;
    logic       rst_n;
    logic       i2c_exec;
    logic       bit_ctrl;
    logic       i2c_rh_wl;
    word_addr_t i2c_addr;
    data_t      i2c_data_w;
    data_t      i2c_data_r;
    logic       i2c_done;
    logic       scl;
    logic       sda_out;
    logic       sda_oe;
    logic       dev_pull;
    logic       dev_busy;
    logic       dev_fault;
    logic       exp_addr16;
    logic       exp_rd;
    word_addr_t dev_wr_addr;
    data_t      dev_wr_data;
    wire        sda_bus = sda_oe ? sda_out : !dev_pull;   // open drain resolve

    logic [31:0] lfsr_state;
    data_t       ref_mem [word_addr_t];
    data_t       last_rd;
    int          done_count;

    i2c_master #(
        .slave_addr (7'h50)
    ) u_i2c_master (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .sda_in     (sda_bus),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

    i2c_eeprom_model #(
        .dev_addr (7'h50)
    ) u_eeprom (
        .scl          (scl),
        .sda          (sda_bus),
        .exp_addr16   (exp_addr16),
        .exp_rd       (exp_rd),
        .sda_pull     (dev_pull),
        .busy         (dev_busy),
        .fault        (dev_fault),
        .last_wr_addr (dev_wr_addr),
        .last_wr_data (dev_wr_data)
    );

    always #10 dri_clk = ~dri_clk;

    always @(posedge dri_clk) begin
        if (i2c_done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge dev_fault) begin
        $display("bus model flagged a protocol error");
        $display("SIMULATION FAILED");
        $fatal(1, "device model fault");
    end

    // ------------------------------------------------------------
    // random numbers and reference memory
    // ------------------------------------------------------------
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic data_t ref_read(input word_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : 8'hFF;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_addr(input string name, input word_addr_t got,
                              input word_addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    // bus released high and no done pulse
    task automatic verify_idle_outputs();
        check_bit("scl", scl, 1'b1);
        check_bit("sda_oe", sda_oe, 1'b1);
        check_bit("sda_out", sda_out, 1'b1);
        check_bit("i2c_done", i2c_done, 1'b0);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!i2c_done) begin
            @(negedge dri_clk);
            n++;
            if (n > DONE_TIMEOUT) begin
                $display("i2c_done did not arrive within %0d cycles", DONE_TIMEOUT);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout");
            end
        end
    endtask

    // one full request, optionally with a stray exec in the middle
    task automatic run_transfer(input logic rd, input logic a16, input word_addr_t addr,
                                input data_t data, input logic poke);
        int         start_count;
        word_addr_t key;
        @(negedge dri_clk);
        start_count = done_count;
        exp_rd      = rd;
        exp_addr16  = a16;
        i2c_exec    = 1'b1;
        bit_ctrl    = a16;
        i2c_rh_wl   = rd;
        i2c_addr    = addr;
        i2c_data_w  = data;
        @(negedge dri_clk);
        i2c_exec   = 1'b0;
        i2c_addr   = ~addr;     // must not matter once latched
        i2c_data_w = ~data;
        if (poke) begin
            repeat (20) @(negedge dri_clk);
            i2c_exec  = 1'b1;
            i2c_rh_wl = !rd;
            bit_ctrl  = !a16;
            repeat (2) @(negedge dri_clk);
            i2c_exec = 1'b0;
        end
        wait_done();
        key = a16 ? addr : {8'h00, addr[7:0]};
        if (rd) begin
            check_data("i2c_data_r", i2c_data_r, ref_read(key));
            last_rd = ref_read(key);
        end else begin
            ref_mem[key] = data;
            check_addr("last_wr_addr", dev_wr_addr, key);
            check_data("last_wr_data", dev_wr_data, data);
            check_data("i2c_data_r", i2c_data_r, last_rd);    // held across writes
        end
        repeat (4) @(negedge dri_clk);
        check_bit("single i2c_done", (done_count - start_count) == 1, 1'b1);
        check_bit("dev_busy", dev_busy, 1'b0);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rd_v;
        logic [31:0] a16_v;
        logic [31:0] hi_v;
        logic [31:0] lo_v;
        logic [31:0] dat_v;
        dri_clk    = 1'b0;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        exp_addr16 = 1'b0;
        exp_rd     = 1'b0;
        lfsr_state = 32'had3b1c16;
        last_rd    = '0;
        done_count = 0;
        repeat (5) @(posedge dri_clk);
        @(negedge dri_clk);
        verify_idle_outputs();      // reset values
        rst_n = 1'b1;
        @(negedge dri_clk);
        verify_idle_outputs();

        run_transfer(1'b0, 1'b0, 16'hC33C, 8'hA5, 1'b0);
        run_transfer(1'b1, 1'b0, 16'hC33C, 8'h00, 1'b0);
        run_transfer(1'b0, 1'b1, 16'h1234, 8'h5A, 1'b0);
        run_transfer(1'b1, 1'b1, 16'h1234, 8'h00, 1'b0);
        run_transfer(1'b1, 1'b1, 16'h7E01, 8'h00, 1'b0);
        check_data("i2c_data_r", i2c_data_r, 8'hFF);     // never written

        run_transfer(1'b0, 1'b1, 16'h0203, 8'hC3, 1'b1);
        run_transfer(1'b1, 1'b1, 16'h0203, 8'h00, 1'b1);

        for (int i = 0; i < 60; i++) begin
            draw_bits(1, rd_v);
            draw_bits(1, a16_v);
            draw_bits(2, hi_v);
            draw_bits(3, lo_v);
            draw_bits(8, dat_v);
            run_transfer(rd_v[0], a16_v[0], {6'd0, hi_v[1:0], 5'd0, lo_v[2:0]},
                         dat_v[7:0], 1'b0);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/i2c_pkg.sv
source/i2c_phase_fsm.sv
source/i2c_bit_engine.sv
source/i2c_master.sv
bench/i2c_eeprom_model.sv
bench/tb_i2c_master.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the I2C master testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_i2c_master \
    -f all.f \
    -o sim_tb_i2c_master

./obj_dir/sim_tb_i2c_master
